/* logic/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------
`define CPU_DATA_W      4       // Accumulator and index register width
`define CPU_INSTR_W     8       // One program memory byte
`define CPU_ADDR_W      12      // Program address space

// ----------------------------------------------------------
// Storage sizes
// ----------------------------------------------------------
`define CPU_NUM_REGS    16      // Index registers R0..R15
`define CPU_STACK_DEPTH 3       // Return stack levels, wraps when full

// ----------------------------------------------------------
// Reset vector
// ----------------------------------------------------------
`define CPU_RESET_PC    0       // First fetch address

`endif

/* logic/cpuPkg.sv */
`include "cpu_defines.svh"

package cpuPkg;

    // ----------------------------------------------------------
    // Instruction encodings
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        oprNop  = 4'h0,
        oprJcn  = 4'h1,
        oprFim  = 4'h2,         // Also SRC, not executed here
        oprJun  = 4'h4,
        oprJms  = 4'h5,
        oprInc  = 4'h6,
        oprAdd  = 4'h8,
        oprSub  = 4'h9,
        oprLd   = 4'hA,
        oprXch  = 4'hB,
        oprBbl  = 4'hC,
        oprLdm  = 4'hD,
        oprEgrp = 4'hE,         // I/O group, only WRR kept
        oprFgrp = 4'hF          // Accumulator and carry group
    } oprCode_t;

    typedef enum logic [3:0] {
        subClb = 4'h0,
        subClc = 4'h1,
        subIac = 4'h2,
        subCmc = 4'h3,
        subCma = 4'h4,
        subRal = 4'h5,
        subRar = 4'h6,
        subTcc = 4'h7,
        subDac = 4'h8,
        subStc = 4'hA
    } accSub_t;

    localparam logic [3:0] ioWrr = 4'h2;    // E group subcode of WRR

    typedef struct packed {
        oprCode_t               opr;
        logic [`CPU_DATA_W-1:0] opa;
    } instrPlain_t;

    typedef struct packed {
        oprCode_t opr;
        logic     invert;       // Negate the whole condition
        logic     accZeroSel;
        logic     carrySel;
        logic     testSel;      // Test pin low
    } instrCond_t;

    typedef union packed {
        instrPlain_t plain;
        instrCond_t  cond;      // JCN view of the same byte
    } instrWord_t;

    // ----------------------------------------------------------
    // Control and status between blocks
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        aluPassReg, aluPassImm, aluAdd, aluSub,
        aluIncReg, aluXch, aluClb, aluClc,
        aluIac, aluCmc, aluCma, aluRal,
        aluRar, aluTcc, aluDac, aluStc
    } aluOp_t;

    typedef struct packed {
        aluOp_t                           aluOp;
        logic [`CPU_DATA_W-1:0]           imm;
        logic [$clog2(`CPU_NUM_REGS)-1:0] regIdx;
        logic                             accWe;
        logic                             carryWe;
        logic                             regWe;
        logic                             portWe;
    } ctrlBus_t;

    typedef struct packed {
        logic                   advance;
        logic                   load;
        logic                   push;    // Saves pc+1 ahead of the load
        logic                   pop;
        logic [`CPU_ADDR_W-1:0] target;
    } pcCtrl_t;

    typedef struct packed {
        logic carry;
        logic accZero;
    } flags_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_ADDR_W-1:0] addr;
    } fetchReq_t;

endpackage

/* logic/regFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuPkg::ctrlBus_t       ctrl,
    input  logic [`CPU_DATA_W-1:0] wrData,
    output logic [`CPU_DATA_W-1:0] rdData
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

    // Single write port, addressed like the read side
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWe) begin
            regs[ctrl.regIdx] <= wrData;
        end
    end

    assign rdData = regs[ctrl.regIdx];      // Combinational read

endmodule

/* logic/arithUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module arithUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuPkg::ctrlBus_t       ctrl,
    input  logic [`CPU_DATA_W-1:0] regValue,
    output logic [`CPU_DATA_W-1:0] regWrData,
    output cpuPkg::flags_t         flags,
    output logic [`CPU_DATA_W-1:0] port,
    output logic                   portStrobe
);

    localparam int W = `CPU_DATA_W;

    logic [W-1:0] acc;
    logic         carry;
    logic [W-1:0] accNext;
    logic         carryNext;
    logic [W-1:0] addB;
    logic         addCin;
    logic [W:0]   sum;              // Carry-out in the top bit

    // ----------------------------------------------------------
    // Shared adder, operands picked per operation
    // ----------------------------------------------------------
    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluSub: begin
                addB   = ~regValue;         // Carry out means no borrow
                addCin = ~carry;
            end
            cpuPkg::aluIac: begin
                addB   = '0;
                addCin = 1'b1;
            end
            cpuPkg::aluDac: begin
                addB   = '1;                // Add minus one
                addCin = 1'b0;
            end
            default: begin
                addB   = regValue;
                addCin = carry;
            end
        endcase
        sum = {1'b0, acc} + {1'b0, addB} + (W+1)'(addCin);
    end

    always_comb begin
        accNext   = acc;
        carryNext = carry;
        regWrData = regValue + W'(1);       // INC result
        case (ctrl.aluOp)
            cpuPkg::aluPassReg: accNext = regValue;
            cpuPkg::aluPassImm: accNext = ctrl.imm;
            cpuPkg::aluAdd, cpuPkg::aluSub, cpuPkg::aluIac, cpuPkg::aluDac: begin
                {carryNext, accNext} = sum;
            end
            cpuPkg::aluIncReg: ;            // Carry untouched
            cpuPkg::aluXch: begin
                accNext   = regValue;
                regWrData = acc;
            end
            cpuPkg::aluClb: begin
                accNext   = '0;
                carryNext = 1'b0;
            end
            cpuPkg::aluClc: carryNext = 1'b0;
            cpuPkg::aluCmc: carryNext = ~carry;
            cpuPkg::aluCma: accNext = ~acc;
            cpuPkg::aluRal: {carryNext, accNext} = {acc, carry};
            cpuPkg::aluRar: {accNext, carryNext} = {carry, acc};
            cpuPkg::aluTcc: begin
                accNext   = W'(carry);
                carryNext = 1'b0;
            end
            cpuPkg::aluStc: carryNext = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc        <= '0;
            carry      <= 1'b0;
            port       <= '0;
            portStrobe <= 1'b0;
        end else begin
            if (ctrl.accWe) begin
                acc <= accNext;
            end
            if (ctrl.carryWe) begin
                carry <= carryNext;
            end
            if (ctrl.portWe) begin
                port <= acc;                // Value before this EXEC edge
            end
            portStrobe <= ctrl.portWe;
        end
    end

    assign flags.carry   = carry;
    assign flags.accZero = (acc == '0);

endmodule

/* logic/pcStack.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module pcStack (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuPkg::pcCtrl_t        pcCtrl,
    output logic [`CPU_ADDR_W-1:0] pc
);

    localparam int AddrW = `CPU_ADDR_W;
    localparam int Depth = `CPU_STACK_DEPTH;
    localparam int SpW   = $clog2(Depth);

    logic [AddrW-1:0] stack [Depth];
    logic [SpW-1:0]   sp;               // Next free slot
    logic [SpW-1:0]   spInc;
    logic [SpW-1:0]   spDec;
    logic [AddrW-1:0] pcPlus1;

    assign pcPlus1 = pc + AddrW'(1);

    // Pointer wraps modulo the depth, oldest entry gets overwritten
    assign spInc = (sp == SpW'(Depth - 1)) ? '0 : sp + SpW'(1);
    assign spDec = (sp == '0) ? SpW'(Depth - 1) : sp - SpW'(1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= AddrW'(`CPU_RESET_PC);
            sp <= '0;
        end else if (pcCtrl.pop) begin
            pc <= stack[spDec];
            sp <= spDec;
        end else if (pcCtrl.load) begin
            pc <= pcCtrl.target;
            if (pcCtrl.push) begin
                sp <= spInc;
            end
        end else if (pcCtrl.advance) begin
            pc <= pcPlus1;
        end
    end

    always_ff @(posedge clk) begin
        if (pcCtrl.push) begin
            stack[sp] <= pcPlus1;           // Return address
        end
    end

endmodule

/* logic/sequencer.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module sequencer (
    input  logic                    clk,
    input  logic                    rstN,
    output logic                    fetchValid,
    input  logic                    fetchAck,
    input  logic [`CPU_INSTR_W-1:0] fetchData,
    input  logic                    testPin,
    input  cpuPkg::flags_t          flags,
    input  logic [`CPU_ADDR_W-1:0]  pc,
    output cpuPkg::ctrlBus_t        ctrl,
    output cpuPkg::pcCtrl_t         pcCtrl
);

    typedef enum logic [1:0] {
        stateFetch,
        stateFetch2,
        stateExec
    } seqState_t;

    seqState_t               state;
    seqState_t               stateNext;
    cpuPkg::instrWord_t      instr;         // First byte
    logic [`CPU_INSTR_W-1:0] instr2;        // Address byte of JUN/JMS/JCN
    cpuPkg::instrWord_t      fetchWord;
    logic                    xfer;
    logic                    twoWord;
    logic                    condMet;
    logic                    jcnTaken;

    assign xfer      = fetchValid & fetchAck;
    assign fetchWord = fetchData;

    always_comb begin
        case (fetchWord.plain.opr)
            cpuPkg::oprJcn, cpuPkg::oprJun, cpuPkg::oprJms: twoWord = 1'b1;
            default:                                         twoWord = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // Fetch/execute state machine
    // ----------------------------------------------------------
    always_comb begin
        stateNext = state;
        case (state)
            stateFetch: begin
                if (xfer) begin
                    stateNext = twoWord ? stateFetch2 : stateExec;
                end
            end
            stateFetch2: begin
                if (xfer) begin
                    stateNext = stateExec;
                end
            end
            default: stateNext = stateFetch;   // EXEC is a single cycle
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= stateFetch;
            fetchValid <= 1'b0;
        end else begin
            state      <= stateNext;
            fetchValid <= (stateNext != stateExec);  // Low only in EXEC
        end
    end

    always_ff @(posedge clk) begin
        if (state == stateFetch && xfer) begin
            instr <= fetchWord;
        end
        if (state == stateFetch2 && xfer) begin
            instr2 <= fetchData;
        end
    end

    // JCN condition, the invert bit applies to the whole OR
    assign condMet  = (instr.cond.testSel & ~testPin) | (instr.cond.carrySel & flags.carry)
                    | (instr.cond.accZeroSel & flags.accZero);
    assign jcnTaken = condMet ^ instr.cond.invert;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    always_comb begin
        ctrl          = '0;
        ctrl.aluOp    = cpuPkg::aluPassReg;
        ctrl.imm      = instr.plain.opa;
        ctrl.regIdx   = instr.plain.opa;
        pcCtrl        = '0;
        pcCtrl.target = {instr.plain.opa, instr2};
        if (state == stateFetch) begin
            pcCtrl.advance = xfer & twoWord;    // Step onto the address byte
        end else if (state == stateExec) begin
            pcCtrl.advance = 1'b1;
            case (instr.plain.opr)
                cpuPkg::oprJcn: begin
                    pcCtrl.target  = {pc[`CPU_ADDR_W-1:`CPU_INSTR_W], instr2};  // Same page
                    pcCtrl.load    = jcnTaken;
                    pcCtrl.advance = ~jcnTaken;
                end
                cpuPkg::oprJun: begin
                    pcCtrl.load    = 1'b1;
                    pcCtrl.advance = 1'b0;
                end
                cpuPkg::oprJms: begin
                    pcCtrl.push    = 1'b1;
                    pcCtrl.load    = 1'b1;
                    pcCtrl.advance = 1'b0;
                end
                cpuPkg::oprInc: begin
                    ctrl.aluOp = cpuPkg::aluIncReg;
                    ctrl.regWe = 1'b1;
                end
                cpuPkg::oprAdd, cpuPkg::oprSub: begin
                    ctrl.aluOp   = (instr.plain.opr == cpuPkg::oprAdd) ? cpuPkg::aluAdd
                                                                       : cpuPkg::aluSub;
                    ctrl.accWe   = 1'b1;
                    ctrl.carryWe = 1'b1;
                end
                cpuPkg::oprLd: ctrl.accWe = 1'b1;
                cpuPkg::oprXch: begin
                    ctrl.aluOp = cpuPkg::aluXch;
                    ctrl.accWe = 1'b1;
                    ctrl.regWe = 1'b1;
                end
                cpuPkg::oprBbl, cpuPkg::oprLdm: begin
                    ctrl.aluOp     = cpuPkg::aluPassImm;
                    ctrl.accWe     = 1'b1;
                    pcCtrl.pop     = (instr.plain.opr == cpuPkg::oprBbl);
                    pcCtrl.advance = (instr.plain.opr == cpuPkg::oprLdm);
                end
                cpuPkg::oprEgrp: ctrl.portWe = (instr.plain.opa == cpuPkg::ioWrr);
                cpuPkg::oprFgrp: begin
                    case (cpuPkg::accSub_t'(instr.plain.opa))
                        cpuPkg::subClb: ctrl.aluOp = cpuPkg::aluClb;
                        cpuPkg::subClc: ctrl.aluOp = cpuPkg::aluClc;
                        cpuPkg::subIac: ctrl.aluOp = cpuPkg::aluIac;
                        cpuPkg::subCmc: ctrl.aluOp = cpuPkg::aluCmc;
                        cpuPkg::subCma: ctrl.aluOp = cpuPkg::aluCma;
                        cpuPkg::subRal: ctrl.aluOp = cpuPkg::aluRal;
                        cpuPkg::subRar: ctrl.aluOp = cpuPkg::aluRar;
                        cpuPkg::subTcc: ctrl.aluOp = cpuPkg::aluTcc;
                        cpuPkg::subDac: ctrl.aluOp = cpuPkg::aluDac;
                        cpuPkg::subStc: ctrl.aluOp = cpuPkg::aluStc;
                        default:        ctrl.aluOp = cpuPkg::aluPassReg;  // Dropped subcodes
                    endcase
                    ctrl.accWe   = !(ctrl.aluOp inside {cpuPkg::aluPassReg, cpuPkg::aluClc,
                                                        cpuPkg::aluCmc, cpuPkg::aluStc});
                    ctrl.carryWe = !(ctrl.aluOp inside {cpuPkg::aluPassReg, cpuPkg::aluCma});
                end
                default: ;                      // Everything else is a no-op
            endcase
        end
    end

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTop (
    input  logic                    clk,
    input  logic                    rstN,
    output cpuPkg::fetchReq_t       fetchReq,
    input  logic                    fetchAck,
    input  logic [`CPU_INSTR_W-1:0] fetchData,
    input  logic                    testPin,
    output logic [`CPU_DATA_W-1:0]  port,
    output logic                    portStrobe
);

    cpuPkg::ctrlBus_t       ctrl;
    cpuPkg::pcCtrl_t        pcCtrl;
    cpuPkg::flags_t         flags;
    logic [`CPU_DATA_W-1:0] regValue;
    logic [`CPU_DATA_W-1:0] regWrData;
    logic [`CPU_ADDR_W-1:0] pc;
    logic                   fetchValid;

    // ----------------------------------------------------------
    // Fetch request to program memory
    // ----------------------------------------------------------
    assign fetchReq.valid = fetchValid;
    assign fetchReq.addr  = pc;

    sequencer uSequencer (
        .clk        (clk),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .fetchAck   (fetchAck),
        .fetchData  (fetchData),
        .testPin    (testPin),
        .flags      (flags),
        .pc         (pc),
        .ctrl       (ctrl),
        .pcCtrl     (pcCtrl)
    );

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------
    arithUnit uArithUnit (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (ctrl),
        .regValue   (regValue),
        .regWrData  (regWrData),
        .flags      (flags),
        .port       (port),
        .portStrobe (portStrobe)
    );

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .wrData (regWrData),
        .rdData (regValue)
    );

    pcStack uPcStack (
        .clk    (clk),
        .rstN   (rstN),
        .pcCtrl (pcCtrl),
        .pc     (pc)
    );

endmodule

/* sim/romModel.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module romModel (
    input  logic                    clk,
    input  logic                    rstN,
    input  cpuPkg::fetchReq_t       fetchReq,
    output logic                    fetchAck,
    output logic [`CPU_INSTR_W-1:0] fetchData
);

    logic [`CPU_INSTR_W-1:0] mem [1 << `CPU_ADDR_W];   // Filled by the testbench
    logic [31:0]             lfsr;
    logic                    pending;                  // Request seen, latency chosen
    int                      waitLeft;

    // Galois LFSR, one step per latency bit
    function automatic int pickLatency();
        int lat;
        lat = 0;
        for (int i = 0; i < 2; i++) begin
            lat  = (lat << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return lat;
    endfunction

    initial begin
        fetchAck  = 1'b0;
        fetchData = '0;
        pending   = 1'b0;
        waitLeft  = 0;
        lfsr      = 32'hf43a;
    end

    always begin
        @(posedge clk);
        #1;
        if (!rstN || fetchAck) begin               // Transfer just completed
            fetchAck = 1'b0;
            pending  = 1'b0;
        end else if (fetchReq.valid) begin
            if (!pending) begin
                pending  = 1'b1;
                waitLeft = pickLatency();
            end
            if (waitLeft == 0) begin
                fetchAck  = 1'b1;
                fetchData = mem[fetchReq.addr];
            end else begin
                waitLeft--;
            end
        end
    end

endmodule

/* sim/tbTop.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbTop;

    logic                    clk;
    logic                    rstN;
    cpuPkg::fetchReq_t       fetchReq;
    logic                    fetchAck;
    logic [`CPU_INSTR_W-1:0] fetchData;
    logic                    testPin;
    logic [3:0]              port;
    logic                    portStrobe;
    logic                    reqValid;
    logic [`CPU_ADDR_W-1:0]  reqAddr;

    // Reference model state
    logic [3:0]              acc;
    logic                    carry;
    logic [3:0]              regs [16];
    logic                    pin;
    logic [`CPU_ADDR_W-1:0]  cursor;           // Next program byte address
    logic [31:0]             lfsr;
    logic [3:0]              expVal [$];
    string                   expName [$];
    logic                    pinAfter [$];     // testPin level after each strobe
    int                      progBytes;
    int                      errors;
    int                      checks;
    int                      cycles;
    int                      cycleLimit;
    logic                    firstSeen;

    assign reqValid = fetchReq.valid;
    assign reqAddr  = fetchReq.addr;

    cpuTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .fetchReq   (fetchReq),
        .fetchAck   (fetchAck),
        .fetchData  (fetchData),
        .testPin    (testPin),
        .port       (port),
        .portStrobe (portStrobe)
    );

    romModel uRom (
        .clk       (clk),
        .rstN      (rstN),
        .fetchReq  (fetchReq),
        .fetchAck  (fetchAck),
        .fetchData (fetchData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
    end

    // ------------------------------------------------------------
    // Handshake and reset checks
    // ------------------------------------------------------------
    assert property (@(posedge clk) (!rstN || $past(!rstN)) |-> !portStrobe)
        else begin
            errors++;
            $display("portStrobe was high during reset or on the first edge after it");
        end

    assert property (@(posedge clk) disable iff (!rstN)
                     (reqValid && !fetchAck) |=> (reqValid && $stable(reqAddr)))
        else begin
            errors++;
            $display("Fetch request dropped or changed address while waiting for fetchAck");
        end

    always @(posedge clk) begin
        if (rstN && reqValid && !firstSeen) begin
            firstSeen = 1'b1;
            checks++;
            assert (reqAddr == `CPU_ADDR_W'(`CPU_RESET_PC))
                else begin
                    errors++;
                    $display("[ERROR] first fetch address expected %h actual %h",
                             `CPU_ADDR_W'(`CPU_RESET_PC), reqAddr);
                end
        end
    end

    // Port check, then move testPin for the next program section
    always @(posedge clk) begin
        if (rstN && portStrobe) begin
            if (expVal.size() == 0) begin
                errors++;
                $display("Port strobe arrived with no value left to expect");
            end else begin
                checks++;
                assert (port == expVal[0])
                    else begin
                        errors++;
                        $display("[ERROR] %s expected %h actual %h", expName[0], expVal[0], port);
                    end
                void'(expVal.pop_front());
                void'(expName.pop_front());
                #1 testPin = pinAfter.pop_front();
            end
        end
    end

    // ------------------------------------------------------------
    // Program builder with reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic emitByte(input logic [7:0] b);
        uRom.mem[cursor] = b;
        cursor++;
        progBytes++;
    endtask

    task automatic loadImm(input logic [3:0] v);
        emitByte({4'hD, v});
        acc = v;
    endtask

    task automatic exchange(input logic [3:0] r);
        logic [3:0] t;
        emitByte({4'hB, r});
        t       = acc;
        acc     = regs[r];
        regs[r] = t;
    endtask

    task automatic loadReg(input logic [3:0] r);
        emitByte({4'hA, r});
        acc = regs[r];
    endtask

    task automatic incReg(input logic [3:0] r);
        emitByte({4'h6, r});
        regs[r] = regs[r] + 4'd1;
    endtask

    task automatic addReg(input logic [3:0] r, input logic sub);
        logic [4:0] s;
        emitByte({sub ? 4'h9 : 4'h8, r});
        if (sub) begin
            s = {1'b0, acc} + {1'b0, ~regs[r]} + {4'b0, ~carry};   // Carry out = no borrow
        end else begin
            s = {1'b0, acc} + {1'b0, regs[r]} + {4'b0, carry};
        end
        {carry, acc} = s;
    endtask

    task automatic accGroup(input logic [3:0] sub);
        emitByte({4'hF, sub});
        case (sub)
            4'h0: {carry, acc} = 5'b0;
            4'h1: carry = 1'b0;
            4'h2: begin
                carry = (acc == 4'hF);
                acc   = acc + 4'd1;
            end
            4'h3: carry = ~carry;
            4'h4: acc = ~acc;
            4'h5: {carry, acc} = {acc, carry};
            4'h6: {acc, carry} = {carry, acc};
            4'h7: begin
                acc   = {3'b0, carry};
                carry = 1'b0;
            end
            4'h8: begin
                carry = (acc != 4'h0);   // No borrow unless acc was zero
                acc   = acc - 4'd1;
            end
            4'hA: carry = 1'b1;
            default: ;
        endcase
    endtask

    task automatic writePort(input string name);
        emitByte(8'hE2);
        expVal.push_back(acc);
        expName.push_back(name);
        pinAfter.push_back(pin);
    endtask

    task automatic setPin(input logic v);
        pin = v;
        pinAfter[pinAfter.size() - 1] = v;
    endtask

    task automatic jump(input logic [3:0] opr, input logic [`CPU_ADDR_W-1:0] target);
        emitByte({opr, target[11:8]});
        emitByte(target[7:0]);
    endtask

    task automatic returnImm(input logic [3:0] v);
        emitByte({4'hC, v});
        acc = v;
    endtask

    // Three nested calls, code placed in execution order
    task automatic callChain();
        logic [`CPU_ADDR_W-1:0] retMain;
        logic [`CPU_ADDR_W-1:0] retA;
        logic [`CPU_ADDR_W-1:0] retB;
        jump(4'h5, 12'h800);
        retMain = cursor;
        cursor  = 12'h800;
        loadImm(4'h1);
        writePort("jms level 1");
        jump(4'h5, 12'h810);
        retA   = cursor;
        cursor = 12'h810;
        loadImm(4'h2);
        writePort("jms level 2");
        jump(4'h5, 12'h820);
        retB   = cursor;
        cursor = 12'h820;
        loadImm(4'h3);
        writePort("jms level 3");
        returnImm(4'h4);
        cursor = retB;
        writePort("bbl to level 2");
        returnImm(4'h6);
        cursor = retA;
        writePort("bbl to level 1");
        returnImm(4'h7);
        cursor = retMain;
        writePort("bbl to main");
    endtask

    task automatic condJump(input logic [3:0] cond);
        logic                   taken;
        logic [`CPU_ADDR_W-1:0] dest;
        while (((cursor + 12'd1) >> 8) != ((cursor + 12'd4) >> 8)) begin
            emitByte(8'h00);                     // Keep target on the same page
        end
        taken = ((cond[0] & ~pin) | (cond[1] & carry) | (cond[2] & (acc == 4'h0))) ^ cond[3];
        dest  = cursor + 12'd4;
        emitByte({4'h1, cond});
        emitByte(dest[7:0]);
        if (taken) begin
            emitByte(8'hD5);
            emitByte(8'hE2);
        end else begin
            loadImm(4'h5);
            writePort($sformatf("jcn %h not taken", cond));
        end
        loadImm(4'hA);
        writePort($sformatf("jcn %h target", cond));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [3:0] accOps [12];
        rstN       = 1'b0;
        testPin    = 1'b1;
        lfsr       = 32'hf43a;
        acc        = '0;
        carry      = 1'b0;
        pin        = 1'b1;
        cursor     = `CPU_ADDR_W'(`CPU_RESET_PC);
        progBytes  = 0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        firstSeen  = 1'b0;
        // Each carry change is read back by the RAL, RAR or TCC after it
        accOps     = '{4'hA, 4'h5, 4'h0, 4'h6, 4'h3, 4'h4,
                       4'h5, 4'h2, 4'h6, 4'h8, 4'h7, 4'h5};
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < (1 << `CPU_ADDR_W); i++) begin
            uRom.mem[i] = 8'(i) ^ 8'(i >> 4);    // Address pattern where no code is placed
        end

        loadImm(4'(randBits(4)));
        exchange(4'd3);
        loadImm(4'(randBits(4)));
        writePort("ldm");
        exchange(4'd3);
        writePort("xch");
        loadReg(4'd3);
        writePort("ld");
        incReg(4'd3);
        loadReg(4'd3);
        writePort("inc then ld");

        for (int i = 0; i < 4; i++) begin
            loadImm(4'(randBits(4)));
            exchange(4'd5);
            loadImm(4'(randBits(4)));
            accGroup(randBits(1) ? 4'hA : 4'h1);
            addReg(4'd5, i[0]);
            writePort(i[0] ? "sub" : "add");
            accGroup(4'h7);
            writePort("tcc after add or sub");
        end

        foreach (accOps[i]) begin
            loadImm(4'(randBits(4)));
            accGroup(accOps[i]);
            writePort($sformatf("acc group %h", accOps[i]));
        end

        jump(4'h4, cursor + 12'd4);
        emitByte(8'hDF);                         // Poison, must be skipped
        emitByte(8'hE2);
        loadImm(4'(randBits(4)));
        writePort("jun target");
        callChain();

        for (int i = 0; i < 8; i++) begin
            writePort("before jcn");
            setPin(randBits(1) != 0);
            accGroup(randBits(1) ? 4'hA : 4'h1);
            loadImm(randBits(1) ? 4'h0 : 4'(randBits(4)));
            condJump(4'(randBits(4)));
        end
        jump(4'h4, cursor);                      // Park
        cycleLimit = 64 + progBytes * 8;         // Worst latency plus exec per byte

        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
        while (expVal.size() != 0 && cycles < cycleLimit) begin
            @(posedge clk);
        end
        if (expVal.size() != 0) begin
            errors++;
            $display("Timeout after %0d cycles with %0d port values still expected",
                     cycles, expVal.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/cpuPkg.sv
logic/regFile.sv
logic/arithUnit.sv
logic/pcStack.sv
logic/sequencer.sv
logic/cpuTop.sv
sim/romModel.sv
sim/tbTop.sv

/* Makefile */
# Verilator build and run of the accumulator core testbench

VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
INCDIRS   ?= -Ilogic
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(INCDIRS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing $(INCDIRS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
